// ==== filelist.f ====
+incdir+.
sw_pkg.sv
reset_stretch.sv
score_config_regs.sv
stream_fifo.sv
sw_pe.sv
sw_engine.sv
sw_accel_top.sv
tb_sw_accel.sv

// ==== reset_stretch.sv ====
// Internal reset generator; holds sys_rst a fixed number of cycles after stream_rst drops
`timescale 1ns/1ns
`include "sw_config.svh"

module reset_stretch (
    input  logic sys_clk,
    input  logic stream_rst,
    output logic sys_rst
);

    localparam int HOLD  = `SW_RST_HOLD_CYCLES;
    localparam int CNT_W = $clog2(`SW_RST_HOLD_CYCLES + 1);

    logic [CNT_W-1:0] hold_cnt;                     // Cycles since stream_rst fell

    // Registered so the internal reset never glitches
    always_ff @(posedge sys_clk or posedge stream_rst) begin
        if (stream_rst) begin
            hold_cnt <= '0;
            sys_rst  <= 1'b1;                       // Assert at once
        end else if (hold_cnt != CNT_W'(HOLD)) begin
            hold_cnt <= hold_cnt + 1'b1;
            sys_rst  <= (hold_cnt != CNT_W'(HOLD - 1)); // Drops on the last count
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ns -Wno-fatal \
    --top-module tb_sw_accel -f filelist.f -o sim_tb &&
./obj_dir/sim_tb || exit 1

// ==== score_config_regs.sv ====
// Scoring table registers; decodes write strobes from the config bus into engine parameters
`timescale 1ns/1ns
`include "sw_config.svh"

module score_config_regs (
    input  logic                  sys_clk,
    input  logic                  sys_rst,
    input  logic                  cfg_wr,
    input  logic [31:0]           cfg_addr,
    input  logic [31:0]           cfg_wdata,
    output sw_pkg::score_params_t params
);

    sw_pkg::score_t wr_val;

    assign wr_val = cfg_wdata[`SW_SCORE_WIDTH-1:0]; // Low bits, sign included

    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            params <= '0;                           // Whole table reads zero
        end else if (cfg_wr) begin
            case (cfg_addr)                         // Exact match only
                `SW_ADDR_SUB_AA:     params.sub_aa     <= wr_val;
                `SW_ADDR_SUB_AC:     params.sub_ac     <= wr_val;
                `SW_ADDR_SUB_AG:     params.sub_ag     <= wr_val;
                `SW_ADDR_SUB_AT:     params.sub_at     <= wr_val;
                `SW_ADDR_SUB_CC:     params.sub_cc     <= wr_val;
                `SW_ADDR_SUB_CG:     params.sub_cg     <= wr_val;
                `SW_ADDR_SUB_CT:     params.sub_ct     <= wr_val;
                `SW_ADDR_SUB_GG:     params.sub_gg     <= wr_val;
                `SW_ADDR_SUB_GT:     params.sub_gt     <= wr_val;
                `SW_ADDR_SUB_TT:     params.sub_tt     <= wr_val;
                `SW_ADDR_GAP_OPEN:   params.gap_open   <= wr_val;
                `SW_ADDR_GAP_EXTEND: params.gap_extend <= wr_val;
                default: ;                          // Unmapped address ignored
            endcase
        end
    end

    // The PEs subtract the penalties, so a negative value would reward gaps
    a_gap_nonneg : assert property (
        @(posedge sys_clk) disable iff (sys_rst)
        params.gap_open >= 0 && params.gap_extend >= 0
    ) else $error("gap penalty programmed negative");

endmodule

// ==== stream_fifo.sv ====
// Ready/valid FIFO with a payload type parameter; buffers the beat and result streams
`timescale 1ns/1ns
`include "sw_config.svh"

module stream_fifo #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     sys_clk,
    input  logic     sys_rst,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_rdy,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_rdy
);

    localparam int DEPTH = `SW_FIFO_DEPTH;
    localparam int PTR_W = $clog2(`SW_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`SW_FIFO_DEPTH + 1);

    payload_t         mem [DEPTH];                  // Circular storage
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;                        // Entries held
    logic [CNT_W-1:0] count_nxt;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign push      = in_valid && in_rdy;
    assign pop       = out_valid && out_rdy;
    assign count_nxt = count + CNT_W'(push) - CNT_W'(pop);
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];                 // Head entry, stable until pop

    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            in_rdy <= 1'b0;                         // Closed while in reset
        end else begin
            if (push) wr_ptr <= ptr_inc(wr_ptr);
            if (pop)  rd_ptr <= ptr_inc(rd_ptr);
            count  <= count_nxt;
            in_rdy <= (count_nxt != CNT_W'(DEPTH)); // Room next cycle
        end
    end

    always_ff @(posedge sys_clk) begin
        if (push) mem[wr_ptr] <= in_data;
    end

    a_no_push_full : assert property (
        @(posedge sys_clk) disable iff (sys_rst) push |-> count != CNT_W'(DEPTH)
    ) else $error("push into full FIFO");

    a_no_pop_empty : assert property (
        @(posedge sys_clk) disable iff (sys_rst) pop |-> count != '0
    ) else $error("pop from empty FIFO");

endmodule

// ==== sw_accel_top.sv ====
// Accelerator top level; connects reset, scoring registers, stream FIFOs and the engine
`timescale 1ns/1ns

module sw_accel_top (
    input  logic               sys_clk,
    input  logic               stream_rst,
    input  logic               cfg_wr,
    input  logic [31:0]        cfg_addr,
    input  logic [31:0]        cfg_wdata,
    input  logic               s_in_valid,
    input  sw_pkg::seq_beat_t  s_in_data,
    output logic               s_in_rdy,
    output logic               s_out_valid,
    output sw_pkg::sw_result_t s_out_data,
    input  logic               s_out_rdy
);

    logic                  sys_rst;             // Stretched internal reset
    sw_pkg::score_params_t params;
    logic                  beat_valid;          // Input FIFO to engine
    logic                  beat_rdy;
    sw_pkg::seq_beat_t     beat;
    logic                  res_valid;           // Engine to output FIFO
    logic                  res_rdy;
    sw_pkg::sw_result_t    res;

    reset_stretch reset_stretch_inst (
        .sys_clk    (sys_clk),
        .stream_rst (stream_rst),
        .sys_rst    (sys_rst)
    );

    score_config_regs score_config_regs_inst (
        .sys_clk   (sys_clk),
        .sys_rst   (sys_rst),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .params    (params)
    );

    stream_fifo #(.payload_t(sw_pkg::seq_beat_t)) in_fifo_inst (
        .sys_clk   (sys_clk),
        .sys_rst   (sys_rst),
        .in_valid  (s_in_valid),
        .in_data   (s_in_data),
        .in_rdy    (s_in_rdy),
        .out_valid (beat_valid),
        .out_data  (beat),
        .out_rdy   (beat_rdy)
    );

    sw_engine sw_engine_inst (
        .sys_clk    (sys_clk),
        .sys_rst    (sys_rst),
        .params     (params),
        .beat_valid (beat_valid),
        .beat       (beat),
        .beat_rdy   (beat_rdy),
        .res_valid  (res_valid),
        .res        (res),
        .res_rdy    (res_rdy)
    );

    stream_fifo #(.payload_t(sw_pkg::sw_result_t)) out_fifo_inst (
        .sys_clk   (sys_clk),
        .sys_rst   (sys_rst),
        .in_valid  (res_valid),
        .in_data   (res),
        .in_rdy    (res_rdy),                   // Also steps the chain
        .out_valid (s_out_valid),
        .out_data  (s_out_data),
        .out_rdy   (s_out_rdy)
    );

endmodule

// ==== sw_config.svh ====
// Build constants for the alignment accelerator; include wherever sizes or addresses are needed
`ifndef SW_CONFIG_SVH
`define SW_CONFIG_SVH

//////////////////////////////
// Array and datapath sizes
//////////////////////////////
`define SW_NUM_PES          8       // PEs in chain, also reference length
`define SW_SCORE_WIDTH      18      // Signed score bits
`define SW_FIFO_DEPTH       4       // Entries per stream FIFO
`define SW_RST_HOLD_CYCLES  16      // Extra internal reset cycles
`define SW_QLEN_WIDTH       8       // Query length counter bits

//////////////////////////////
// Scoring register map
//////////////////////////////
`define SW_ADDR_SUB_AA      32'h00  // Byte addresses, step of four
`define SW_ADDR_SUB_AC      32'h04
`define SW_ADDR_SUB_AG      32'h08
`define SW_ADDR_SUB_AT      32'h0C
`define SW_ADDR_SUB_CC      32'h10
`define SW_ADDR_SUB_CG      32'h14
`define SW_ADDR_SUB_CT      32'h18
`define SW_ADDR_SUB_GG      32'h1C
`define SW_ADDR_SUB_GT      32'h20
`define SW_ADDR_SUB_TT      32'h24
`define SW_ADDR_GAP_OPEN    32'h28  // Subtracted on gap start
`define SW_ADDR_GAP_EXTEND  32'h2C  // Subtracted per gap step

`endif

// ==== sw_engine.sv ====
// Alignment engine; loads the reference into the PE chain, streams queries, collects results
`timescale 1ns/1ns
`include "sw_config.svh"

module sw_engine (
    input  logic                  sys_clk,
    input  logic                  sys_rst,
    input  sw_pkg::score_params_t params,
    input  logic                  beat_valid,
    input  sw_pkg::seq_beat_t     beat,
    output logic                  beat_rdy,
    output logic                  res_valid,
    output sw_pkg::sw_result_t    res,
    input  logic                  res_rdy
);

    localparam int NUM_PES = `SW_NUM_PES;
    localparam int QW      = `SW_QLEN_WIDTH;
    localparam int QCNT_W  = $clog2(`SW_NUM_PES + 2);

    sw_pkg::cell_link_t links [NUM_PES+1];      // links[k] feeds PE k
    sw_pkg::base_t      ref_chain [1:NUM_PES];  // ref_chain[k] held by PE k
    sw_pkg::cell_link_t tail;                   // Leaving the last PE
    logic [NUM_PES-1:0] chain_busy;             // Valid beat per PE output
    logic [QCNT_W-1:0]  q_count;                // Queries in flight
    logic               step;
    logic               ref_shift;
    logic               q_enter;
    logic               q_leave;
    sw_pkg::score_t     run_best;               // Max over earlier columns
    sw_pkg::score_t     cur_best;
    logic [QW-1:0]      run_len;
    logic [QW-1:0]      cur_len;

    //////////////////////////////
    // Input routing
    //////////////////////////////
    assign step      = res_rdy;                 // Result FIFO has room
    assign ref_shift = beat_valid && beat.is_ref && (q_count == '0);
    assign beat_rdy  = beat.is_ref ? (q_count == '0) : step;
    assign ref_chain[NUM_PES] = beat.base;      // New base enters at the far end

    always_comb begin
        links[0]       = '0;                    // Row 0 of the matrix
        links[0].valid = beat_valid && !beat.is_ref;
        links[0].first = beat.first;
        links[0].last  = beat.last;
        links[0].base  = beat.base;
    end

    assign q_enter = step && links[0].valid && beat.first;
    assign q_leave = step && tail.valid && tail.last;

    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            q_count <= '0;
        end else if (q_enter != q_leave) begin
            q_count <= q_enter ? q_count + 1'b1 : q_count - 1'b1;
        end
    end

    //////////////////////////////
    // PE chain
    //////////////////////////////
    for (genvar k = 0; k < NUM_PES; k++) begin : g_pe
        if (k == 0) begin : g_head
            sw_pe sw_pe_inst (
                .sys_clk   (sys_clk),
                .sys_rst   (sys_rst),
                .step      (step),
                .ref_shift (ref_shift),
                .ref_in    (ref_chain[1]),
                .ref_out   (),              // Reference stops at PE 0
                .params    (params),
                .link_in   (links[0]),
                .link_out  (links[1])
            );
        end else begin : g_body
            sw_pe sw_pe_inst (
                .sys_clk   (sys_clk),
                .sys_rst   (sys_rst),
                .step      (step),
                .ref_shift (ref_shift),
                .ref_in    (ref_chain[k+1]),
                .ref_out   (ref_chain[k]),
                .params    (params),
                .link_in   (links[k]),
                .link_out  (links[k+1])
            );
        end
        assign chain_busy[k] = links[k+1].valid;
    end

    //////////////////////////////
    // Result collection
    //////////////////////////////
    assign tail     = links[NUM_PES];
    assign cur_best = tail.first ? tail.best : sw_pkg::score_max(run_best, tail.best);
    assign cur_len  = tail.first ? QW'(1) : run_len + QW'(1);

    always_ff @(posedge sys_clk) begin
        if (step && tail.valid) begin
            run_best <= cur_best;               // Restarts on first
            run_len  <= cur_len;
        end
    end

    assign res_valid = tail.valid && tail.last; // Held while the chain is frozen
    assign res       = '{score: cur_best, query_len: cur_len};

    // A reload under a live query would corrupt its remaining columns
    a_ref_idle : assert property (
        @(posedge sys_clk) disable iff (sys_rst) ref_shift |-> chain_busy == '0
    ) else $error("reference shifted with query beats in the chain");

endmodule

// ==== sw_pe.sv ====
// Systolic cell; scores one affine-gap matrix cell per query beat against its reference base
`timescale 1ns/1ns

module sw_pe (
    input  logic                  sys_clk,
    input  logic                  sys_rst,
    input  logic                  step,         // Chain advance
    input  logic                  ref_shift,    // Reference load
    input  sw_pkg::base_t         ref_in,
    output sw_pkg::base_t         ref_out,
    input  sw_pkg::score_params_t params,
    input  sw_pkg::cell_link_t    link_in,
    output sw_pkg::cell_link_t    link_out
);

    sw_pkg::base_t  ref_q;                      // Reference base r(i)
    sw_pkg::score_t diag_q;                     // H(i-1,j-1)
    sw_pkg::score_t h_q;                        // H(i,j-1)
    sw_pkg::score_t e_q;                        // E(i,j-1)
    sw_pkg::score_t d_in;
    sw_pkg::score_t h_left;
    sw_pkg::score_t e_left;
    sw_pkg::score_t e_new;
    sw_pkg::score_t f_new;
    sw_pkg::score_t h_new;

    function automatic sw_pkg::score_t sub_score(input sw_pkg::score_params_t p,
                                                 input sw_pkg::base_t a,
                                                 input sw_pkg::base_t b);
        sw_pkg::base_t lo;
        sw_pkg::base_t hi;
        lo = (a < b) ? a : b;                   // Table is symmetric
        hi = (a < b) ? b : a;
        case ({lo, hi})
            4'b0000: sub_score = p.sub_aa;
            4'b0001: sub_score = p.sub_ac;
            4'b0010: sub_score = p.sub_ag;
            4'b0011: sub_score = p.sub_at;
            4'b0101: sub_score = p.sub_cc;
            4'b0110: sub_score = p.sub_cg;
            4'b0111: sub_score = p.sub_ct;
            4'b1010: sub_score = p.sub_gg;
            4'b1011: sub_score = p.sub_gt;
            default: sub_score = p.sub_tt;      // Only TT remains
        endcase
    endfunction

    assign ref_out = ref_q;

    always_comb begin
        d_in   = link_in.first ? '0 : diag_q;   // Column j=0 is all zero
        h_left = link_in.first ? '0 : h_q;
        e_left = link_in.first ? '0 : e_q;
        e_new  = sw_pkg::score_max(h_left - params.gap_open, e_left - params.gap_extend);
        f_new  = sw_pkg::score_max(link_in.h - params.gap_open, link_in.f - params.gap_extend);
        h_new  = sw_pkg::score_max(sw_pkg::score_max('0, d_in + sub_score(params, ref_q,
                                   link_in.base)), sw_pkg::score_max(e_new, f_new));
    end

    // Row state, only moves on a real beat
    always_ff @(posedge sys_clk) begin
        if (ref_shift) ref_q <= ref_in;
        if (step && link_in.valid) begin
            diag_q <= link_in.h;                // Becomes next beat's diagonal
            h_q    <= h_new;
            e_q    <= e_new;
        end
    end

    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            link_out <= '0;
        end else if (step) begin
            link_out.valid <= link_in.valid;    // Bubble passes as invalid
            if (link_in.valid) begin
                link_out.first <= link_in.first;
                link_out.last  <= link_in.last;
                link_out.base  <= link_in.base;
                link_out.h     <= h_new;
                link_out.f     <= f_new;
                link_out.best  <= sw_pkg::score_max(link_in.best, h_new);
            end
        end
    end

    // Upstream H feeds F and the next diagonal and must already be floored at zero
    a_h_nonneg : assert property (
        @(posedge sys_clk) disable iff (sys_rst)
        step && link_in.valid |-> link_in.h >= 0 && link_in.best >= link_in.h
    ) else $error("PE received a negative H or a best below it");

endmodule

// ==== sw_pkg.sv ====
// Data types of the alignment accelerator, referenced by scoped name from RTL and testbench
`include "sw_config.svh"

package sw_pkg;

    typedef logic [1:0] base_t;                         // A=0 C=1 G=2 T=3
    typedef logic signed [`SW_SCORE_WIDTH-1:0] score_t; // Two's complement score

    typedef struct packed {
        logic  is_ref;                                  // Reference base, else query
        logic  first;                                   // Query start
        logic  last;                                    // Query end
        base_t base;
    } seq_beat_t;

    typedef struct packed {
        score_t sub_aa;                                 // Symmetric pair scores
        score_t sub_ac;
        score_t sub_ag;
        score_t sub_at;
        score_t sub_cc;
        score_t sub_cg;
        score_t sub_ct;
        score_t sub_gg;
        score_t sub_gt;
        score_t sub_tt;
        score_t gap_open;                               // Non-negative penalty
        score_t gap_extend;                             // Non-negative penalty
    } score_params_t;

    typedef struct packed {
        logic   valid;                                  // Query beat present
        logic   first;
        logic   last;
        base_t  base;                                   // Query base
        score_t h;                                      // H of upstream cell
        score_t f;                                      // Gap along the reference
        score_t best;                                   // Column maximum so far
    } cell_link_t;

    typedef struct packed {
        score_t                    score;               // Best local score
        logic [`SW_QLEN_WIDTH-1:0] query_len;           // Beats first..last
    } sw_result_t;

    function automatic score_t score_max(input score_t a, input score_t b);
        return (a > b) ? a : b;                         // Signed compare
    endfunction

endpackage

// ==== tb_sw_model.svh ====
// Expected-result model and random source for the accelerator testbench; included inside its module
`ifndef TB_SW_MODEL_SVH
`define TB_SW_MODEL_SVH

int unsigned lcg_state = 32'haecb;                  // Fixed seed, repeatable runs

// Linear congruential step, upper bits are the better ones
function int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state >> 8;
endfunction

function int rand_range(input int lo, input int hi);
    return lo + int'(lcg_next() % (hi - lo + 1));   // Inclusive both ends
endfunction

function automatic int max2(input int a, input int b);
    return (a > b) ? a : b;
endfunction

// Full 4x4 table, lower half mirrored from the upper half
function automatic int pair_score(input sw_pkg::score_params_t p,
                                  input sw_pkg::base_t a, input sw_pkg::base_t b);
    int tab [4][4];
    tab[0][0] = p.sub_aa;
    tab[0][1] = p.sub_ac;
    tab[0][2] = p.sub_ag;
    tab[0][3] = p.sub_at;
    tab[1][1] = p.sub_cc;
    tab[1][2] = p.sub_cg;
    tab[1][3] = p.sub_ct;
    tab[2][2] = p.sub_gg;
    tab[2][3] = p.sub_gt;
    tab[3][3] = p.sub_tt;
    for (int i = 1; i < 4; i++)
        for (int j = 0; j < i; j++)
            tab[i][j] = tab[j][i];                  // Symmetric pairs
    return tab[a][b];
endfunction

// Plain affine-gap local alignment, rows are reference, columns are query
function automatic int model_score(input sw_pkg::score_params_t p,
                                   input sw_pkg::base_t r [8],
                                   input sw_pkg::base_t q [32], input int qlen);
    int h [9][33];
    int e [9][33];
    int f [9][33];
    int best;
    best = 0;
    for (int i = 0; i < 9; i++)
        for (int j = 0; j < 33; j++) begin
            h[i][j] = 0;                            // Borders stay zero
            e[i][j] = 0;
            f[i][j] = 0;
        end
    for (int j = 1; j <= qlen; j++)
        for (int i = 1; i <= 8; i++) begin
            e[i][j] = max2(h[i][j-1] - p.gap_open, e[i][j-1] - p.gap_extend);
            f[i][j] = max2(h[i-1][j] - p.gap_open, f[i-1][j] - p.gap_extend);
            h[i][j] = max2(max2(0, h[i-1][j-1] + pair_score(p, r[i-1], q[j-1])),
                           max2(e[i][j], f[i][j]));
            best    = max2(best, h[i][j]);
        end
    return best;
endfunction

`endif

// ==== tb_sw_accel.sv ====
// Testbench for the alignment accelerator; drives bus and streams, checks results by assertion
`timescale 1ns/1ns
`include "sw_config.svh"

module tb_sw_accel;

    localparam int HOLD       = `SW_RST_HOLD_CYCLES;
    localparam int QW         = `SW_QLEN_WIDTH;
    localparam int WAIT_LIMIT = 500;                // Cycles allowed per wait

    logic                  sys_clk;
    logic                  stream_rst;
    logic                  cfg_wr;
    logic [31:0]           cfg_addr;
    logic [31:0]           cfg_wdata;
    logic                  s_in_valid;
    sw_pkg::seq_beat_t     s_in_data;
    logic                  s_in_rdy;
    logic                  s_out_valid;
    sw_pkg::sw_result_t    s_out_data;
    logic                  s_out_rdy;

    sw_pkg::score_params_t cur_params;              // Table as last programmed
    sw_pkg::base_t         ref_seq [8];
    sw_pkg::base_t         q_seq [32];
    int                    q_len;
    sw_pkg::sw_result_t    exp_mem [256];           // Expected results in order
    sw_pkg::sw_result_t    exp_head;                // Next one due
    int                    exp_wr = 0;
    int                    exp_rd = 0;
    int                    rst_age = 0;             // Cycles since stream_rst fell

    `include "tb_sw_model.svh"

    sw_accel_top sw_accel_top_inst (
        .sys_clk     (sys_clk),
        .stream_rst  (stream_rst),
        .cfg_wr      (cfg_wr),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .s_in_valid  (s_in_valid),
        .s_in_data   (s_in_data),
        .s_in_rdy    (s_in_rdy),
        .s_out_valid (s_out_valid),
        .s_out_data  (s_out_data),
        .s_out_rdy   (s_out_rdy)
    );

    initial begin
        sys_clk = 1'b0;
        forever #20 sys_clk = ~sys_clk;             // 40 ns period
    end

    assign exp_head = exp_mem[exp_rd[7:0]];

    always @(posedge sys_clk) begin
        if (s_out_valid && s_out_rdy) exp_rd <= exp_rd + 1;  // Retire on transfer
        if (stream_rst) rst_age <= 0;
        else if (rst_age < 1000) rst_age <= rst_age + 1;
    end

    //////////////////////////////
    // Failure reporting
    //////////////////////////////
    task automatic run_failed();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_failed(input string why);
        $display("Error at %0t: %s", $time, why);
        run_failed();
    endtask

    task automatic value_error(input string name, input int got, input int exp);
        $display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        run_failed();
    endtask

    //////////////////////////////
    // Checks
    //////////////////////////////
    a_rdy_in_reset : assert property (@(posedge sys_clk)
        (stream_rst || rst_age < HOLD) |-> !s_in_rdy)
        else check_failed("s_in_rdy high while the internal reset should hold");

    a_out_expected : assert property (@(posedge sys_clk) s_out_valid |-> exp_rd < exp_wr)
        else check_failed("s_out_valid high with no result outstanding");

    a_score : assert property (@(posedge sys_clk)
        s_out_valid && s_out_rdy |-> s_out_data.score == exp_head.score)
        else value_error("s_out_data.score", $sampled(s_out_data.score),
                         $sampled(exp_head.score));

    a_qlen : assert property (@(posedge sys_clk)
        s_out_valid && s_out_rdy |-> s_out_data.query_len == exp_head.query_len)
        else value_error("s_out_data.query_len", $sampled(s_out_data.query_len),
                         $sampled(exp_head.query_len));

    // Stalled result must hold until taken
    a_out_hold : assert property (@(posedge sys_clk)
        s_out_valid && !s_out_rdy |=> s_out_valid && $stable(s_out_data))
        else check_failed("s_out_valid or s_out_data changed before the transfer");

    //////////////////////////////
    // Drivers
    //////////////////////////////
    task automatic next_cycle();
        @(posedge sys_clk);
        #2;                                         // Drive after the edge
    endtask

    task automatic write_cfg(input logic [31:0] addr, input sw_pkg::score_t val);
        cfg_wr    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = 32'(int'(val));                 // Sign extended
        next_cycle();
        cfg_wr    = 1'b0;
    endtask

    task automatic set_params(input sw_pkg::score_params_t p);
        write_cfg(`SW_ADDR_SUB_AA, p.sub_aa);
        write_cfg(`SW_ADDR_SUB_AC, p.sub_ac);
        write_cfg(`SW_ADDR_SUB_AG, p.sub_ag);
        write_cfg(`SW_ADDR_SUB_AT, p.sub_at);
        write_cfg(`SW_ADDR_SUB_CC, p.sub_cc);
        write_cfg(`SW_ADDR_SUB_CG, p.sub_cg);
        write_cfg(`SW_ADDR_SUB_CT, p.sub_ct);
        write_cfg(`SW_ADDR_SUB_GG, p.sub_gg);
        write_cfg(`SW_ADDR_SUB_GT, p.sub_gt);
        write_cfg(`SW_ADDR_SUB_TT, p.sub_tt);
        write_cfg(`SW_ADDR_GAP_OPEN, p.gap_open);
        write_cfg(`SW_ADDR_GAP_EXTEND, p.gap_extend);
        cur_params = p;
    endtask

    function automatic sw_pkg::score_params_t make_params(input int match, input int mismatch,
                                                          input int open, input int ext);
        sw_pkg::score_params_t p;
        p            = '{default: sw_pkg::score_t'(mismatch)};
        p.sub_aa     = sw_pkg::score_t'(match);     // Diagonal of the table
        p.sub_cc     = sw_pkg::score_t'(match);
        p.sub_gg     = sw_pkg::score_t'(match);
        p.sub_tt     = sw_pkg::score_t'(match);
        p.gap_open   = sw_pkg::score_t'(open);
        p.gap_extend = sw_pkg::score_t'(ext);
        return p;
    endfunction

    function automatic sw_pkg::score_params_t random_params();
        sw_pkg::score_params_t p;
        p = make_params(rand_range(1, 5), 0, rand_range(0, 5), rand_range(0, 3));
        p.sub_cc = sw_pkg::score_t'(rand_range(1, 5));
        p.sub_gg = sw_pkg::score_t'(rand_range(1, 5));
        p.sub_tt = sw_pkg::score_t'(rand_range(1, 5));
        p.sub_ac = sw_pkg::score_t'(rand_range(-4, 0));
        p.sub_ag = sw_pkg::score_t'(rand_range(-4, 0));
        p.sub_at = sw_pkg::score_t'(rand_range(-4, 0));
        p.sub_cg = sw_pkg::score_t'(rand_range(-4, 0));
        p.sub_ct = sw_pkg::score_t'(rand_range(-4, 0));
        p.sub_gt = sw_pkg::score_t'(rand_range(-4, 0));
        return p;
    endfunction

    function automatic sw_pkg::base_t base_of(input byte c);
        case (c)
            "A": return 2'd0;
            "C": return 2'd1;
            "G": return 2'd2;
            default: return 2'd3;
        endcase
    endfunction

    task automatic set_ref(input string s);
        for (int i = 0; i < 8; i++) ref_seq[i] = base_of(s[i]);
    endtask

    task automatic set_query(input string s);
        q_len = s.len();
        for (int j = 0; j < q_len; j++) q_seq[j] = base_of(s[j]);
    endtask

    task automatic random_query(input int lo, input int hi);
        q_len = rand_range(lo, hi);
        for (int j = 0; j < q_len; j++) q_seq[j] = sw_pkg::base_t'(lcg_next());
    endtask

    // Valid and data hold until the beat is taken
    task automatic send_beat(input logic ref_flag, input logic first_flag,
                             input logic last_flag, input sw_pkg::base_t b);
        int waited;
        waited     = 0;
        s_in_data  = '{is_ref: ref_flag, first: first_flag, last: last_flag, base: b};
        s_in_valid = 1'b1;
        while (!s_in_rdy) begin
            if (waited == WAIT_LIMIT) check_failed("Timeout, input beat never accepted");
            next_cycle();
            waited++;
        end
        next_cycle();                               // Transfer on this edge
        s_in_valid = 1'b0;
    endtask

    task automatic send_ref();
        for (int i = 0; i < 8; i++) send_beat(1'b1, 1'b0, 1'b0, ref_seq[i]);
    endtask

    task automatic push_expected(input int score, input int len);
        exp_mem[exp_wr[7:0]] = '{score: sw_pkg::score_t'(score), query_len: QW'(len)};
        exp_wr++;
    endtask

    task automatic send_query();
        for (int j = 0; j < q_len; j++) send_beat(1'b0, j == 0, j == q_len - 1, q_seq[j]);
    endtask

    task automatic send_modeled();
        push_expected(model_score(cur_params, ref_seq, q_seq, q_len), q_len);
        send_query();
    endtask

    task automatic wait_in_level(input logic level, input string why);
        int waited;
        waited = 0;
        while (s_in_rdy !== level) begin
            if (waited == WAIT_LIMIT) check_failed(why);
            next_cycle();
            waited++;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_rd != exp_wr) begin
            if (waited == 4 * WAIT_LIMIT) check_failed("Timeout, results missing from output");
            next_cycle();
            waited++;
        end
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////
    initial begin
        stream_rst = 1'b0;
        cfg_wr     = 1'b0;
        cfg_addr   = '0;
        cfg_wdata  = '0;
        s_in_valid = 1'b0;
        s_in_data  = '0;
        s_out_rdy  = 1'b1;
        #1 stream_rst = 1'b1;                       // Clean rising edge
        repeat (5) next_cycle();
        stream_rst = 1'b0;
        wait_in_level(1'b1, "Timeout, s_in_rdy did not rise after reset");

        // Query equal to reference, full diagonal
        set_params(make_params(2, -1, 3, 1));
        set_ref("ACGTTGCA");
        send_ref();
        set_query("ACGTTGCA");
        push_expected(16, 8);
        send_query();
        wait_drain();

        // Random reference, table and queries, one at a time
        for (int i = 0; i < 8; i++) ref_seq[i] = sw_pkg::base_t'(lcg_next());
        send_ref();
        set_params(random_params());
        repeat (6) begin
            random_query(1, 20);
            send_modeled();
            wait_drain();
        end

        // Back to back, several queries in the chain
        repeat (5) begin
            random_query(1, 8);
            send_modeled();
        end
        wait_drain();

        // Output stalled until the input side backs up
        s_out_rdy = 1'b0;
        fork
            repeat (12) begin
                random_query(2, 4);
                send_modeled();
            end
            begin
                wait_in_level(1'b0, "Timeout, s_in_rdy never fell under back-pressure");
                repeat (40) next_cycle();
                s_out_rdy = 1'b1;
            end
        join
        wait_drain();

        // Unmapped write is harmless, longer gap cost shows up
        set_params(make_params(2, -3, 2, 1));
        set_ref("ACGTACGT");
        send_ref();
        set_query("ACGCGT");                        // Two-base gap against reference
        send_modeled();
        wait_drain();
        write_cfg(32'h30, sw_pkg::score_t'(7));
        send_modeled();
        wait_drain();
        write_cfg(`SW_ADDR_GAP_EXTEND, sw_pkg::score_t'(5));
        cur_params.gap_extend = sw_pkg::score_t'(5);
        send_modeled();
        wait_drain();

        $display("NO ERRORS");
        $finish;
    end

endmodule
